/* compile.f */
verilog/trackball_pkg.sv
verilog/host_pkg.sv
verilog/quad_axis_counter.sv
verilog/ball_read_port.sv
verilog/trackball_counter.sv
sim/trackball_counter_properties.sv
sim/trackball_counter_tb.sv

/* sim/trackball_counter_properties.sv */
`timescale 1ns/100ps
`default_nettype none

// input legality and flag behaviour of the trackball counter.
module trackball_counter_properties (
    input wire                       clk,
    input wire                       rst,
    input wire trackball_pkg::quad_t quad_x,
    input wire trackball_pkg::quad_t quad_y,
    input wire host_pkg::buttons_t   buttons,
    input wire host_pkg::read_req_t  read_req,
    input wire                       cfn,
    input wire                       sfn
);

    // high from reset until a ball or button input leaves its idle level.
    logic quiet;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quiet <= 1'b1;
        end else if (quad_x != '0 || quad_y != '0 || buttons != 3'b111) begin
            quiet <= 1'b0;
        end
    end

    // a legal quadrature pair moves one bit at a time.
    quad_x_one_bit: assert property (@(posedge clk) disable iff (rst)
        (quad_x ^ $past(quad_x)) != 2'b11)
        else $error("x quadrature pair changed both bits in one cycle");

    quad_y_one_bit: assert property (@(posedge clk) disable iff (rst)
        (quad_y ^ $past(quad_y)) != 2'b11)
        else $error("y quadrature pair changed both bits in one cycle");

    // the counter flag stays quiet while the host has the chip selected.
    cfn_quiet_when_selected: assert property (@(posedge clk) disable iff (rst)
        !$past(read_req.csn) |-> cfn)
        else $error("counter flag went low after a selected cycle");

    // nothing to report before the first input change.
    flags_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        quiet |-> (cfn && sfn))
        else $error("a flag went low before any input changed");

endmodule

bind trackball_counter trackball_counter_properties u_properties (
    .clk      (clk),
    .rst      (rst),
    .quad_x   (quad_x),
    .quad_y   (quad_y),
    .buttons  (buttons),
    .read_req (read_req),
    .cfn      (cfn),
    .sfn      (sfn)
);

`default_nettype wire

/* sim/trackball_counter_tb.sv */
`timescale 1ns/100ps
`default_nettype none

// testbench for the trackball counter chip.
// each data line moves one axis, then reads both axes back.
module trackball_counter_tb;

    logic                        clk;
    logic                        rst;
    trackball_pkg::quad_t        quad_x;
    trackball_pkg::quad_t        quad_y;
    logic                        x_rstn;
    logic                        y_rstn;
    host_pkg::buttons_t          buttons;
    host_pkg::read_req_t         read_req;
    logic [host_pkg::byte_w-1:0] dout;
    logic                        cfn;
    logic                        sfn;

    // reference counts and Gray positions per axis.
    // index 0 is x.
    trackball_pkg::count_t model_count [2];
    logic [1:0]            gray_pos [2];

    logic [31:0] rng_state;
    string       test_name;

    trackball_counter u_trackball_counter (
        .clk      (clk),
        .rst      (rst),
        .quad_x   (quad_x),
        .quad_y   (quad_y),
        .x_rstn   (x_rstn),
        .y_rstn   (y_rstn),
        .buttons  (buttons),
        .read_req (read_req),
        .dout     (dout),
        .cfn      (cfn),
        .sfn      (sfn)
    );

    // 40 ns period.
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Gray state for a position on the cycle 00, 01, 11, 10 (b then a).
    function automatic trackball_pkg::quad_t gray_code(input logic [1:0] pos);
        trackball_pkg::quad_t q;
        q.b = pos[1];
        q.a = pos[1] ^ pos[0];
        return q;
    endfunction

    // high byte as the host should see it with steady buttons.
    function automatic host_pkg::hi_byte_t expected_hi(input trackball_pkg::count_t count,
                                                       input host_pkg::buttons_t btn);
        host_pkg::hi_byte_t h;
        h.sfn      = btn.leftn & btn.rightn & btn.middlen;
        h.leftn    = btn.leftn;
        h.rightn   = btn.rightn;
        h.middlen  = btn.middlen;
        h.count_hi = count[11:8];
        return h;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %s %s expected %02h actual %02h",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_hi(input string what, input host_pkg::hi_byte_t exp,
                            input host_pkg::hi_byte_t act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %s %s expected %02h actual %02h",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %s %s expected %0b actual %0b",
                               test_name, what, exp, act));
        end
    endtask

    task automatic drive_quad(input int axis);
        if (axis == 0) begin
            quad_x = gray_code(gray_pos[0]);
        end else begin
            quad_y = gray_code(gray_pos[1]);
        end
    endtask

    // one Gray step, then wait until the count has taken it.
    task automatic take_step(input int axis, input bit up, input bit flag_expected);
        int waited;
        @(posedge clk);
        #2;
        gray_pos[axis] = gray_pos[axis] + (up ? 2'd1 : 2'd3);
        drive_quad(axis);
        if (up) begin
            model_count[axis] = model_count[axis] + trackball_pkg::count_t'(1);
        end else begin
            model_count[axis] = model_count[axis] - trackball_pkg::count_t'(1);
        end
        if (flag_expected) begin
            // cfn drops at the same edge that applies the step.
            waited = 0;
            @(posedge clk);
            #1;
            while (cfn !== 1'b0) begin
                waited++;
                if (waited > 6) begin
                    fail_now({"counter flag never went low after a step in ", test_name});
                end
                @(posedge clk);
                #1;
            end
        end else begin
            // the count takes the step three edges after the drive.
            repeat (3) begin
                @(posedge clk);
                #1;
                check_flag("cfn selected", 1'b1, cfn);
            end
        end
    endtask

    // a step lands on the edge where the clear is low and is lost.
    task automatic clear_axis(input int axis, input bit up);
        @(posedge clk);
        #2;
        gray_pos[axis] = gray_pos[axis] + (up ? 2'd1 : 2'd3);
        drive_quad(axis);
        @(posedge clk);
        @(posedge clk);
        #2;
        if (axis == 0) x_rstn = 1'b0;
        else y_rstn = 1'b0;
        @(posedge clk);
        #2;
        x_rstn = 1'b1;
        y_rstn = 1'b1;
        model_count[axis] = '0;
    endtask

    // dout holds the selected byte one edge after the selects.
    task automatic read_byte(input int axis, input host_pkg::byte_sel_e bsel,
                             output logic [7:0] val);
        @(posedge clk);
        #2;
        read_req.csn      = 1'b0;
        read_req.byte_sel = bsel;
        read_req.axis_sel = host_pkg::axis_sel_e'(axis[0]);
        @(posedge clk);
        #1;
        val = dout;
    endtask

    task automatic check_axis(input int axis, input string lo_s, input string hi_s);
        logic [7:0]         lo_val;
        logic [7:0]         hi_val;
        logic [7:0]         file_lo;
        logic [7:0]         file_hi;
        host_pkg::hi_byte_t hi_exp;
        string              tag;
        tag    = (axis == 0) ? "x" : "y";
        hi_exp = expected_hi(model_count[axis], buttons);
        if (lo_s != "--") begin
            if ($sscanf(lo_s, "%h", file_lo) != 1 || $sscanf(hi_s, "%h", file_hi) != 1) begin
                fail_now({"bad expected byte in data line ", test_name});
            end
            check_byte({tag, " model lo"}, file_lo, model_count[axis][7:0]);
            check_hi({tag, " model hi"}, host_pkg::hi_byte_t'(file_hi), hi_exp);
        end
        read_byte(axis, host_pkg::byte_lo, lo_val);
        check_byte({tag, " lo"}, model_count[axis][7:0], lo_val);
        read_byte(axis, host_pkg::byte_hi, hi_val);
        check_hi({tag, " hi"}, hi_exp, host_pkg::hi_byte_t'(hi_val));
    endtask

    task automatic run_line(input string line);
        string      axis_s;
        string      dir_s;
        string      steps_s;
        string      sel_s;
        string      btn_s;
        string      lo_s;
        string      hi_s;
        string      sfn_s;
        int         clr;
        int         steps;
        int         axis;
        bit         up;
        bit         sel_high;
        logic [2:0] btn;
        logic       model_sfn;
        logic       prev_sfn;
        if ($sscanf(line, "%s %s %s %s %d %s %s %s %s %s", test_name, axis_s, dir_s,
                    steps_s, clr, sel_s, btn_s, lo_s, hi_s, sfn_s) != 10) begin
            fail_now({"malformed data line: ", line});
        end
        axis     = (axis_s == "y") ? 1 : 0;
        up       = (dir_s == "u");
        sel_high = (sel_s == "h");
        if (steps_s == "r") begin
            rng_state = xorshift32(rng_state);
            steps     = 1 + int'(rng_state % 48);
        end else if ($sscanf(steps_s, "%d", steps) != 1) begin
            fail_now({"bad step count in data line ", test_name});
        end
        if (btn_s == "r") begin
            rng_state = xorshift32(rng_state);
            btn       = rng_state[2:0];
        end else if ($sscanf(btn_s, "%h", btn) != 1) begin
            fail_now({"bad button value in data line ", test_name});
        end
        model_sfn = &btn;
        prev_sfn  = buttons.leftn & buttons.rightn & buttons.middlen;
        // sfn lags the buttons by one cycle.
        @(posedge clk);
        #2;
        buttons = host_pkg::buttons_t'(btn);
        // the old level holds until the next edge.
        #1;
        check_flag("sfn early", prev_sfn, sfn);
        @(posedge clk);
        #1;
        check_flag("sfn lag", model_sfn, sfn);
        @(posedge clk);
        #2;
        read_req.csn = sel_high;
        if (clr != 0) begin
            clear_axis(axis, up);
        end
        for (int i = 0; i < steps; i++) begin
            take_step(axis, up, sel_high);
        end
        @(posedge clk);
        #1;
        check_flag("cfn idle", 1'b1, cfn);
        // the other axis must keep its own count.
        check_axis(axis, lo_s, hi_s);
        check_axis(1 - axis, "--", "--");
        if (sfn_s != "-") begin
            check_flag("model sfn", (sfn_s == "1"), model_sfn);
        end
        check_flag("sfn", model_sfn, sfn);
        @(posedge clk);
        #2;
        read_req.csn = 1'b1;
    endtask

    initial begin
        int    fd;
        int    tests_run;
        string line;
        rst            = 1'b1;
        quad_x         = '0;
        quad_y         = '0;
        x_rstn         = 1'b1;
        y_rstn         = 1'b1;
        buttons        = '1;
        read_req       = '{csn: 1'b1, byte_sel: host_pkg::byte_lo, axis_sel: host_pkg::axis_x};
        model_count[0] = '0;
        model_count[1] = '0;
        gray_pos[0]    = 2'd0;
        gray_pos[1]    = 2'd0;
        rng_state      = 32'h15d6c68f;
        tests_run      = 0;
        test_name      = "reset";
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        fd = $fopen("sim/trackball_tests.txt", "r");
        if (fd == 0) begin
            fail_now("could not open the test data file");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // skip column notes and blank lines.
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            run_line(line);
            tests_run++;
        end
        $fclose(fd);
        if (tests_run == 0) begin
            fail_now("no test lines were found in the data file");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim/trackball_tests.txt */
# name axis(x|y) dir(u|d) steps(dec|r) clear(0|1) csn_during_steps(h|l)
# buttons(hex lmr|r) exp_lo(hex|--) exp_hi(hex|--) exp_sfn(0|1|-)
reset_x      x u 0   0 h 7 00 f0 1
reset_y      y u 0   0 h 7 00 f0 1
up_x         x u 25  0 h 7 19 f0 1
down_y       y d 9   0 h 7 f7 ff 1
more_x       x u 300 0 h 7 45 f1 1
wrap_down_x  x d 330 0 h 7 fb ff 1
wrap_up_y    y u 20  0 h 7 0b f0 1
clear_x      x u 3   1 h 7 03 f0 1
clear_y      y d 0   1 h 7 00 f0 1
selected_x   x u 12  0 l 7 0f f0 1
selected_y   y d 4   0 l 7 fc ff 1
left_btn     x u 0   0 h 3 0f 30 0
right_btn    x u 0   0 h 5 0f 50 0
middle_btn   x u 0   0 h 6 0f 60 0
release_btn  x u 0   0 h 7 0f f0 1
rand_x       x u r   0 h r -- -- -
rand_y       y d r   0 h r -- -- -
rand_sel_x   x d r   0 l 7 -- -- -
final_x      x u 1   1 h 7 01 f0 1
final_y      y u 2   1 h 7 02 f0 1

/* verilog/ball_read_port.sv */
`timescale 1ns/100ps
`default_nettype none

// host side of the trackball chip.
// builds the byte asked for by the selects
// and drives the counter and switch flags.
module ball_read_port (
    input  wire                                clk,
    input  wire                                rst,
    input  wire trackball_pkg::axis_status_t   status_x,
    input  wire trackball_pkg::axis_status_t   status_y,
    input  wire host_pkg::buttons_t            buttons,
    input  wire host_pkg::read_req_t           read_req,
    output logic [host_pkg::byte_w-1:0]        dout,
    output logic                               cfn,
    output logic                               sfn
);

    // count of the axis picked by axis_sel.
    trackball_pkg::count_t sel_count;

    // the two candidate bytes.
    logic [host_pkg::byte_w-1:0] lo_byte;
    host_pkg::hi_byte_t          hi_byte;

    // byte that dout takes at the next edge.
    logic [host_pkg::byte_w-1:0] next_byte;

    // any button held down.
    logic any_pressed;

    // any axis stepping this cycle.
    logic any_moved;

    // axis mux.
    always_comb begin
        if (read_req.axis_sel == host_pkg::axis_y) begin
            sel_count = status_y.count;
        end else begin
            sel_count = status_x.count;
        end
    end

    // byte layout.
    // the low byte is just the bottom of the count.
    // the high byte carries the registered switch flag,
    // the live button levels and the top nibble of the count.
    always_comb begin
        lo_byte          = sel_count[host_pkg::byte_w-1:0];
        hi_byte.sfn      = sfn;
        hi_byte.leftn    = buttons.leftn;
        hi_byte.rightn   = buttons.rightn;
        hi_byte.middlen  = buttons.middlen;
        hi_byte.count_hi = sel_count[trackball_pkg::count_w-1 -: host_pkg::count_hi_w];
    end

    // byte mux.
    always_comb begin
        if (read_req.byte_sel == host_pkg::byte_hi) begin
            next_byte = hi_byte;
        end else begin
            next_byte = lo_byte;
        end
    end

    // buttons are active low, so one low input means pressed.
    assign any_pressed = !(buttons.leftn && buttons.rightn && buttons.middlen);

    assign any_moved = status_x.moved || status_y.moved;

    // output registers.
    // dout is valid one cycle after the selects.
    // reads never feed back into the counters.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= '0;
            sfn  <= 1'b1;
            cfn  <= 1'b1;
        end else begin
            dout <= next_byte;
            // switch flag lags the buttons by one cycle.
            sfn  <= !any_pressed;
            // counter flag only reports while the host is away.
            // it drops at the same edge that applies the step.
            cfn  <= !(read_req.csn && any_moved);
        end
    end

endmodule

`default_nettype wire

/* verilog/host_pkg.sv */
`default_nettype none

// host read side of the trackball chip.
// the host reads one byte per access.
package host_pkg;

    // width of the host data bus.
    localparam int byte_w = 8;

    // count bits that travel in the high byte.
    localparam int count_hi_w = 4;

    // which axis the host wants to read.
    typedef enum logic {
        axis_x = 1'b0,
        axis_y = 1'b1
    } axis_sel_e;

    // which half of the count the host wants to read.
    typedef enum logic {
        byte_lo = 1'b0,
        byte_hi = 1'b1
    } byte_sel_e;

    // read controls, all plain levels.
    // csn high means the chip is not selected.
    typedef struct packed {
        logic      csn;
        byte_sel_e byte_sel;
        axis_sel_e axis_sel;
    } read_req_t;

    // the three ball buttons, low when pressed.
    typedef struct packed {
        logic leftn;
        logic rightn;
        logic middlen;
    } buttons_t;

    // high byte as the host sees it, top bit first.
    typedef struct packed {
        logic                  sfn;
        logic                  leftn;
        logic                  rightn;
        logic                  middlen;
        logic [count_hi_w-1:0] count_hi;
    } hi_byte_t;

endpackage

`default_nettype wire

/* verilog/quad_axis_counter.sv */
`timescale 1ns/100ps
`default_nettype none

// one axis of the trackball chip.
// turns a quadrature pair into up and down steps
// and keeps the wrapping 12-bit count.
module quad_axis_counter (
    input  wire                         clk,
    input  wire                         rst,
    input  wire trackball_pkg::quad_t   quad,
    input  wire                         clear_n,
    output trackball_pkg::axis_status_t status
);

    // input pair as sampled at the last edge.
    trackball_pkg::quad_t quad_q;

    // pair as it was one edge before that.
    trackball_pkg::quad_t quad_prev;

    // bit 0 tracks a, bit 1 tracks b.
    logic [1:0] chg;
    logic [1:0] chg_q;

    // direction of the last change per input, 1 for a rise.
    logic [1:0] phase;
    logic       phase_diff;

    // decoded step for this cycle.
    trackball_pkg::step_e step;

    // the axis count itself.
    trackball_pkg::count_t count;

    // an edge shows up as a difference between the two sampled values.
    assign chg = quad_q ^ quad_prev;

    // phases disagree on every other Gray state.
    assign phase_diff = phase[0] ^ phase[1];

    // sampling, edge capture and phase tracking.
    // an input change sampled at edge k is seen as an edge at k+1.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quad_q    <= '0;
            quad_prev <= '0;
            chg_q     <= '0;
            phase     <= '0;
        end else begin
            quad_q    <= quad;
            quad_prev <= quad_q;
            chg_q     <= chg;
            // a rise leaves the input at 1, a fall at 0.
            if (chg[0]) begin
                phase[0] <= quad_q.a;
            end
            if (chg[1]) begin
                phase[1] <= quad_q.b;
            end
        end
    end

    // decode the registered edges against the updated phases.
    // edge on a with unequal phases, or on b with equal ones, counts up.
    always_comb begin
        step = trackball_pkg::step_none;
        if ((chg_q[0] && phase_diff) || (chg_q[1] && !phase_diff)) begin
            step = trackball_pkg::step_up;
        end else if ((chg_q[0] && !phase_diff) || (chg_q[1] && phase_diff)) begin
            step = trackball_pkg::step_down;
        end
    end

    // count update, one cycle after the edge was seen.
    // the clear input wins over a step in the same cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (!clear_n) begin
            count <= '0;
        end else begin
            case (step)
                trackball_pkg::step_up: begin
                    count <= count + trackball_pkg::count_t'(1);
                end
                trackball_pkg::step_down: begin
                    // wraps to 4095 when counting down from zero.
                    count <= count - trackball_pkg::count_t'(1);
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // status to the read port.
    // moved follows the decoder, so the flag sees every decoded step.
    always_comb begin
        status.count = count;
        status.moved = (step != trackball_pkg::step_none);
    end

endmodule

`default_nettype wire

/* verilog/trackball_counter.sv */
`timescale 1ns/100ps
`default_nettype none

// trackball counter chip.
// two quadrature axes, three buttons and a byte wide read port.
module trackball_counter (
    input  wire                          clk,
    input  wire                          rst,
    // ball quadrature pairs.
    input  wire trackball_pkg::quad_t    quad_x,
    input  wire trackball_pkg::quad_t    quad_y,
    // per axis count clears, low active.
    input  wire                          x_rstn,
    input  wire                          y_rstn,
    input  wire host_pkg::buttons_t      buttons,
    input  wire host_pkg::read_req_t     read_req,
    output wire [host_pkg::byte_w-1:0]   dout,
    // counter flag, low on activity while not selected.
    output wire                          cfn,
    // switch flag, low while a button is pressed.
    output wire                          sfn
);

    // count and step activity of each axis.
    trackball_pkg::axis_status_t status_x;
    trackball_pkg::axis_status_t status_y;

    // horizontal axis.
    quad_axis_counter u_axis_x (
        .clk     (clk),
        .rst     (rst),
        .quad    (quad_x),
        .clear_n (x_rstn),
        .status  (status_x)
    );

    // vertical axis.
    quad_axis_counter u_axis_y (
        .clk     (clk),
        .rst     (rst),
        .quad    (quad_y),
        .clear_n (y_rstn),
        .status  (status_y)
    );

    // host read port and flags.
    ball_read_port u_read_port (
        .clk      (clk),
        .rst      (rst),
        .status_x (status_x),
        .status_y (status_y),
        .buttons  (buttons),
        .read_req (read_req),
        .dout     (dout),
        .cfn      (cfn),
        .sfn      (sfn)
    );

endmodule

`default_nettype wire

/* verilog/trackball_pkg.sv */
`default_nettype none

// quadrature counting side of the trackball chip.
// one count per axis, two axes on the part.
package trackball_pkg;

    // width of one axis count, fixed by the part.
    localparam int count_w = 12;

    // signed position of one axis.
    // it wraps modulo 4096 in both directions.
    typedef logic [count_w-1:0] count_t;

    // one quadrature pair as it arrives from the ball.
    // a sits in bit 0 and b in bit 1.
    typedef struct packed {
        logic b;
        logic a;
    } quad_t;

    // decoded movement of one axis in one cycle.
    // only one of up or down can apply per cycle.
    typedef enum logic [1:0] {
        step_none = 2'd0,
        step_up   = 2'd1,
        step_down = 2'd2
    } step_e;

    // what each axis counter hands to the read port.
    // moved is high in the cycle whose closing edge applies a step,
    // so the counter flag can be raised at that same edge.
    typedef struct packed {
        count_t count;
        logic   moved;
    } axis_status_t;

endpackage

`default_nettype wire
